//--- logic/cdc_fifo_pkg.sv
// Dual-clock FIFO package holding the FIFO sizes, the shared types and the Gray encoder
`default_nettype none

package cdc_fifo_pkg;

  // Number of words the FIFO can hold
  localparam int DEPTH = 8;

  // A count carries one bit more than an address so full and empty differ
  localparam int ADDR_WIDTH  = $clog2(DEPTH);
  localparam int COUNT_WIDTH = ADDR_WIDTH + 1;
  localparam int DATA_WIDTH  = 16;

  // Flops in each Gray count synchronizer
  localparam int SYNC_STAGES = 2;

  // Binary or Gray push and pop counts, wrapping modulo twice DEPTH
  typedef logic [COUNT_WIDTH-1:0] count_t;
  typedef logic [ADDR_WIDTH-1:0]  addr_t;
  typedef logic [DATA_WIDTH-1:0]  data_t;

  // Binary to Gray conversion, so that only one bit changes per increment
  function automatic count_t bin_to_gray(count_t bin);
    return bin ^ (bin >> 1);
  endfunction

endpackage : cdc_fifo_pkg

`default_nettype wire

//--- logic/fifo_ram_if.sv
// Storage array interface bundling the push-side write port and the pop-side read port
`default_nettype none

interface fifo_ram_if import cdc_fifo_pkg::*; ();

  // Write port, owned by the push domain
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;

  // Read port, addressed from the pop domain
  addr_t rd_addr;
  data_t rd_data;

  // Push flag manager side
  modport writer (output wr_en, output wr_addr, output wr_data);

  // Pop flag manager side, which also sees the word read back
  modport reader (output rd_addr, input rd_data);

  // The array itself
  modport ram (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);

endinterface : fifo_ram_if

`default_nettype wire

//--- logic/gray_sync.sv
// Gray count synchronizer that moves a count into another clock domain and decodes it
`default_nettype none

module gray_sync import cdc_fifo_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  count_t gray_in,
  output count_t bin_out
);

  // Synchronizer chain, stage 0 is the one that may go metastable
  count_t sync_q [SYNC_STAGES];

  // Last stage of the chain, stable in the destination domain
  count_t gray_stable;

  // The source changes one bit per step, so any sampled value is either
  // the old count or the new one and never a mix of the two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q <= '{default: '0};
    end else begin
      sync_q[0] <= gray_in;
      for (int s = 1; s < SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  assign gray_stable = sync_q[SYNC_STAGES-1];

  // Gray to binary decode
  // Each binary bit is the XOR of all Gray bits at and above its position
  always_comb begin
    for (int i = 0; i < COUNT_WIDTH; i++) begin
      bin_out[i] = ^(gray_stable >> i);
    end
  end

endmodule : gray_sync

`default_nettype wire

//--- logic/push_flag_mgr.sv
// Push flag manager keeping the push count, its Gray copy, the free-slot count and full
`default_nettype none

module push_flag_mgr import cdc_fifo_pkg::*; (
  input  logic      push_clk,
  input  logic      rst_n,
  input  logic      push_valid,
  input  data_t     push_data,
  input  count_t    pop_count,
  output count_t    push_count_gray,
  output count_t    push_slots,
  output logic      full,
  fifo_ram_if.writer ram
);

  // Strobe that survives the full check
  logic   push_accept;

  // Binary push count, one bit wider than the RAM address
  count_t push_count;
  count_t push_count_next;

  // Occupancy as seen from the push side
  count_t items_next;
  count_t slots_next;
  logic   full_next;

  // A push strobe while full is simply lost, there is no back-pressure
  assign push_accept = push_valid && !full;

  // The accepted word goes straight to the array
  // It lands at the next edge together with the count update
  assign ram.wr_en   = push_accept;
  assign ram.wr_addr = push_count[ADDR_WIDTH-1:0];
  assign ram.wr_data = push_data;

  // Wraps naturally at twice DEPTH because of the extra count bit
  assign push_count_next = push_count + count_t'(push_accept);

  // Items in flight, using the pop count that has come through the synchronizer
  // The pop count lags behind the real one, so this can only overestimate
  // the occupancy and full stays on the safe side
  assign items_next = push_count_next - pop_count;
  assign slots_next = count_t'(DEPTH) - items_next;
  assign full_next  = (slots_next == '0);

  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      push_count <= '0;
    end else begin
      push_count <= push_count_next;
    end
  end

  // Slots and full follow a push one cycle after the strobe
  // They also pick up freed slots whenever the synchronized pop count moves
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      push_slots <= count_t'(DEPTH);
      full       <= 1'b0;
    end else begin
      push_slots <= slots_next;
      full       <= full_next;
    end
  end

  // Registered Gray copy of the next count
  // The flop keeps combinational glitches off the crossing, and since it
  // loads on the same edge as the RAM write, the word is already stored
  // before the pop side can see the new count
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      push_count_gray <= '0;
    end else begin
      push_count_gray <= bin_to_gray(push_count_next);
    end
  end

endmodule : push_flag_mgr

`default_nettype wire

//--- logic/pop_flag_mgr.sv
// Pop flag manager keeping the pop count, its Gray copy, the item count and empty
`default_nettype none

module pop_flag_mgr import cdc_fifo_pkg::*; (
  input  logic      pop_clk,
  input  logic      rst_n,
  input  logic      pop,
  input  count_t    push_count,
  output count_t    pop_count_gray,
  output count_t    pop_items,
  output logic      empty,
  fifo_ram_if.reader ram,
  output data_t     pop_data
);

  // Strobe that survives the empty check
  logic   pop_accept;

  // Binary pop count, wraps at twice DEPTH like the push count
  count_t pop_count;
  count_t pop_count_next;

  // Occupancy as seen from the pop side
  count_t items_next;
  logic   empty_next;

  // A pop strobe while empty is ignored
  assign pop_accept = pop && !empty;

  assign pop_count_next = pop_count + count_t'(pop_accept);

  // The synchronized push count lags the real one, so the pop side may
  // report fewer items than are stored and never more
  assign items_next = push_count - pop_count_next;
  assign empty_next = (items_next == '0);

  // Head of the FIFO sits at the low bits of the pop count
  assign ram.rd_addr = pop_count[ADDR_WIDTH-1:0];

  // Asynchronous read, valid only while empty is low
  assign pop_data = ram.rd_data;

  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      pop_count <= '0;
    end else begin
      pop_count <= pop_count_next;
    end
  end

  // Items and empty update on the same edge that takes a pop,
  // and one edge after a push count leaves the synchronizer
  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      pop_items <= '0;
      empty     <= 1'b1;
    end else begin
      pop_items <= items_next;
      empty     <= empty_next;
    end
  end

  // Gray copy of the next pop count for the crossing back to the push side
  // Registered so the push domain only ever samples a clean flop output
  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      pop_count_gray <= '0;
    end else begin
      pop_count_gray <= bin_to_gray(pop_count_next);
    end
  end

endmodule : pop_flag_mgr

`default_nettype wire

//--- logic/fifo_ram.sv
// FIFO storage array written on the push clock and read asynchronously by the pop side
`default_nettype none

module fifo_ram import cdc_fifo_pkg::*; (
  input  logic   push_clk,
  fifo_ram_if.ram ram
);

  // Flop array, one word per FIFO entry
  data_t mem [DEPTH];

  // Single write port in the push domain
  // The write completes on the edge that also advances the push count
  always_ff @(posedge push_clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Combinational read
  // The pop side only reads an entry after the push count covering it
  // has crossed over, so the addressed word is stable by then
  assign ram.rd_data = mem[ram.rd_addr];

endmodule : fifo_ram

`default_nettype wire

//--- logic/cdc_fifo.sv
// Dual-clock FIFO top level joining the flag managers, the count synchronizers and the RAM
`default_nettype none

module cdc_fifo import cdc_fifo_pkg::*; (
  // Push domain
  input  logic   push_clk,
  input  logic   rst_n,
  input  logic   push_valid,
  input  data_t  push_data,
  output logic   full,
  output count_t push_slots,

  // Pop domain
  input  logic   pop_clk,
  input  logic   pop,
  output data_t  pop_data,
  output logic   empty,
  output count_t pop_items
);

  // Gray counts leaving their home domain
  count_t push_count_gray;
  count_t pop_count_gray;

  // Binary counts after the crossing
  count_t push_count_sync;
  count_t pop_count_sync;

  // Write and read ports of the storage array
  fifo_ram_if u_ram_if ();

  push_flag_mgr u_push_flag_mgr (
    .push_clk        (push_clk),
    .rst_n           (rst_n),
    .push_valid      (push_valid),
    .push_data       (push_data),
    .pop_count       (pop_count_sync),
    .push_count_gray (push_count_gray),
    .push_slots      (push_slots),
    .full            (full),
    .ram             (u_ram_if.writer)
  );

  // Push count into the pop domain
  gray_sync u_push_count_sync (
    .clk     (pop_clk),
    .rst_n   (rst_n),
    .gray_in (push_count_gray),
    .bin_out (push_count_sync)
  );

  pop_flag_mgr u_pop_flag_mgr (
    .pop_clk        (pop_clk),
    .rst_n          (rst_n),
    .pop            (pop),
    .push_count     (push_count_sync),
    .pop_count_gray (pop_count_gray),
    .pop_items      (pop_items),
    .empty          (empty),
    .ram            (u_ram_if.reader),
    .pop_data       (pop_data)
  );

  // Pop count back into the push domain
  gray_sync u_pop_count_sync (
    .clk     (push_clk),
    .rst_n   (rst_n),
    .gray_in (pop_count_gray),
    .bin_out (pop_count_sync)
  );

  fifo_ram u_fifo_ram (
    .push_clk (push_clk),
    .ram      (u_ram_if.ram)
  );

endmodule : cdc_fifo

`default_nettype wire

//--- tests/cdc_fifo_chk.sv
// Push flag manager checker asserting slot range, full consistency and no write while full
`default_nettype none

module cdc_fifo_chk import cdc_fifo_pkg::*; (
  input logic   push_clk,
  input logic   rst_n,
  input count_t push_slots,
  input logic   full,
  input logic   wr_en
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures seen so far
  int fail_count = 0;

  // The slot count can never go above the number of entries
  slots_in_range: assert property (
    @(posedge push_clk) disable iff (!rst_n)
      push_slots <= count_t'(DEPTH)
  ) else begin
    $error("push_slots went above DEPTH");
    fail_count++;
  end

  // Full is just a registered view of zero free slots
  full_matches_slots: assert property (
    @(posedge push_clk) disable iff (!rst_n)
      full == (push_slots == '0)
  ) else begin
    $error("full disagrees with push_slots");
    fail_count++;
  end

  // A write while full would overrun the oldest unread word
  no_write_when_full: assert property (
    @(posedge push_clk) disable iff (!rst_n)
      !(wr_en && full)
  ) else begin
    $error("RAM written while full");
    fail_count++;
  end

endmodule : cdc_fifo_chk

// Attached to every push flag manager
// The write enable is taken from its interface port
bind push_flag_mgr cdc_fifo_chk u_push_flag_chk (
  .push_clk   (push_clk),
  .rst_n      (rst_n),
  .push_slots (push_slots),
  .full       (full),
  .wr_en      (ram.wr_en)
);

`default_nettype wire

//--- tests/cdc_fifo_tb.sv
// Dual-clock FIFO testbench running table-driven push and pop phases against a reference queue
`default_nettype none

module cdc_fifo_tb import cdc_fifo_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PHASES   = 7;
  localparam int SETTLE_LIMIT = 20;
  localparam int IDLE_LIMIT   = 100;

  // One row of the stimulus table
  // Densities are strobe chances out of eight
  typedef struct packed {
    logic [7:0] pushes;
    logic [7:0] pops;
    logic [3:0] push_dens;
    logic [3:0] pop_dens;
    logic       exp_full;
    logic       exp_empty;
    logic       try_push_full;
    logic       try_pop_empty;
  } phase_t;

  logic   push_clk;
  logic   pop_clk;
  logic   rst_n;
  logic   push_valid;
  data_t  push_data;
  logic   full;
  count_t push_slots;
  logic   pop;
  data_t  pop_data;
  logic   empty;
  count_t pop_items;

  phase_t      phases [NUM_PHASES];
  data_t       ref_q [$];
  logic [15:0] push_rng;
  logic [15:0] pop_rng;
  int          value_errors;
  int          timeouts;
  int          assert_fails;

  cdc_fifo u_cdc_fifo (
    .push_clk   (push_clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .full       (full),
    .push_slots (push_slots),
    .pop_clk    (pop_clk),
    .pop        (pop),
    .pop_data   (pop_data),
    .empty      (empty),
    .pop_items  (pop_items)
  );

  // 20 ns push clock and 28 ns pop clock, so their edges drift against each other
  initial begin
    push_clk = 1'b0;
    forever #10 push_clk = ~push_clk;
  end

  initial begin
    pop_clk = 1'b0;
    forever #14 pop_clk = ~pop_clk;
  end

  // Polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Steps the LFSR once per bit and takes the new feedback bit each time
  task automatic take_bits(inout logic [15:0] state, input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_next(state);
      bits  = {bits[14:0], state[0]};
    end
  endtask

  function automatic phase_t make_phase(input int pushes, input int pops, input int push_dens,
                                        input int pop_dens, input logic exp_full,
                                        input logic exp_empty, input logic try_full,
                                        input logic try_empty);
    phase_t ph;
    ph.pushes        = 8'(pushes);
    ph.pops          = 8'(pops);
    ph.push_dens     = 4'(push_dens);
    ph.pop_dens      = 4'(pop_dens);
    ph.exp_full      = exp_full;
    ph.exp_empty     = exp_empty;
    ph.try_push_full = try_full;
    ph.try_pop_empty = try_empty;
    return ph;
  endfunction

  // Fill and drain first, then mixed traffic that wraps the counts several times
  task automatic load_table();
    phases[0] = make_phase(8, 0, 8, 0, 1'b1, 1'b0, 1'b1, 1'b0);
    phases[1] = make_phase(0, 8, 0, 8, 1'b0, 1'b1, 1'b0, 1'b1);
    phases[2] = make_phase(20, 20, 5, 6, 1'b0, 1'b1, 1'b0, 1'b0);
    phases[3] = make_phase(30, 24, 6, 4, 1'b0, 1'b0, 1'b0, 1'b0);
    phases[4] = make_phase(10, 16, 3, 7, 1'b0, 1'b1, 1'b0, 1'b0);
    phases[5] = make_phase(40, 32, 7, 3, 1'b1, 1'b0, 1'b1, 1'b0);
    phases[6] = make_phase(0, 8, 0, 5, 1'b0, 1'b1, 1'b0, 1'b1);
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input count_t got, input count_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Drives the push side of a phase and strobes only while full is low
  task automatic run_pushes(input int n, input int dens);
    int          pushed;
    int          idle;
    logic [15:0] r;
    pushed = 0;
    idle   = 0;
    while (pushed < n) begin
      @(negedge push_clk);
      take_bits(push_rng, 3, r);
      if (!full && int'(r[2:0]) < dens) begin
        take_bits(push_rng, 16, r);
        push_data  = r;
        push_valid = 1'b1;
        ref_q.push_back(r);
        pushed++;
        idle = 0;
      end else begin
        push_valid = 1'b0;
        idle++;
        if (idle > IDLE_LIMIT) begin
          timeouts++;
          $display("Timeout at %0t: push side stalled with %0d of %0d words pushed",
                   $time, pushed, n);
          break;
        end
      end
    end
    @(negedge push_clk);
    push_valid = 1'b0;
  endtask

  // Drives the pop side of a phase
  // Every word taken must be the head of the reference queue
  task automatic run_pops(input int n, input int dens);
    int          popped;
    int          idle;
    logic [15:0] r;
    data_t       exp;
    popped = 0;
    idle   = 0;
    while (popped < n) begin
      @(negedge pop_clk);
      take_bits(pop_rng, 3, r);
      if (!empty && int'(r[2:0]) < dens) begin
        // An empty reference queue here means the DUT offered a word that was never pushed
        exp = (ref_q.size() != 0) ? ref_q.pop_front() : 'x;
        check_data(pop_data, exp, "popped word");
        pop = 1'b1;
        popped++;
        idle = 0;
      end else begin
        pop = 1'b0;
        idle++;
        if (idle > IDLE_LIMIT) begin
          timeouts++;
          $display("Timeout at %0t: pop side stalled with %0d of %0d words popped",
                   $time, popped, n);
          break;
        end
      end
    end
    @(negedge pop_clk);
    pop = 1'b0;
  endtask

  // Waits until the push side shows the free slots the reference queue leaves
  // Sampled on the push clock where the push outputs are stable
  task automatic settle_push();
    int waited;
    waited = 0;
    @(negedge push_clk);
    while (int'(push_slots) != DEPTH - ref_q.size()) begin
      if (waited == SETTLE_LIMIT) begin
        timeouts++;
        $display("Timeout at %0t: push_slots did not settle to %0d free slots",
                 $time, DEPTH - ref_q.size());
        return;
      end
      @(negedge push_clk);
      waited++;
    end
  endtask

  // Waits until the pop side shows as many items as the reference queue holds
  // Sampled on the pop clock where the pop outputs are stable
  task automatic settle_pop();
    int waited;
    waited = 0;
    @(negedge pop_clk);
    while (int'(pop_items) != ref_q.size()) begin
      if (waited == SETTLE_LIMIT) begin
        timeouts++;
        $display("Timeout at %0t: pop_items did not settle to %0d stored words",
                 $time, ref_q.size());
        return;
      end
      @(negedge pop_clk);
      waited++;
    end
  endtask

  // Sends one push strobe into a full FIFO
  // The word never enters the reference queue
  task automatic refused_push();
    @(negedge push_clk);
    push_data  = 16'hdead;
    push_valid = 1'b1;
    @(negedge push_clk);
    push_valid = 1'b0;
    check_flag(full, 1'b1, "full after a refused push");
    check_count(push_slots, '0, "push_slots after a refused push");
  endtask

  // One pop strobe into an empty FIFO
  task automatic refused_pop();
    @(negedge pop_clk);
    pop = 1'b1;
    @(negedge pop_clk);
    pop = 1'b0;
    check_flag(empty, 1'b1, "empty after a refused pop");
    check_count(pop_items, '0, "pop_items after a refused pop");
  endtask

  initial begin
    rst_n        = 1'b0;
    push_valid   = 1'b0;
    push_data    = '0;
    pop          = 1'b0;
    push_rng     = 16'd83;
    pop_rng      = 16'd83;
    value_errors = 0;
    timeouts     = 0;
    assert_fails = 0;
    load_table();

    // 16 push cycles cover more than 11 pop cycles, so both domains see reset
    repeat (16) @(negedge push_clk);
    rst_n = 1'b1;

    @(negedge push_clk);
    check_flag(full, 1'b0, "full after reset");
    check_count(push_slots, count_t'(DEPTH), "push_slots after reset");
    @(negedge pop_clk);
    check_flag(empty, 1'b1, "empty after reset");
    check_count(pop_items, '0, "pop_items after reset");

    for (int p = 0; p < NUM_PHASES && timeouts == 0; p++) begin
      fork
        run_pushes(phases[p].pushes, phases[p].push_dens);
        run_pops(phases[p].pops, phases[p].pop_dens);
      join
      // Each side is checked on its own clock once it has caught up
      settle_push();
      check_count(push_slots, count_t'(DEPTH - ref_q.size()), "push_slots after settling");
      check_flag(full, phases[p].exp_full, "full after settling");
      settle_pop();
      check_count(pop_items, count_t'(ref_q.size()), "pop_items after settling");
      check_flag(empty, phases[p].exp_empty, "empty after settling");
      if (phases[p].try_push_full) begin
        refused_push();
      end
      if (phases[p].try_pop_empty) begin
        refused_pop();
      end
    end

    // Failures of the bound assertions count against the run as well
    assert_fails = u_cdc_fifo.u_push_flag_mgr.u_push_flag_chk.fail_count;

    $display("Summary: %0d value errors, %0d timeouts, %0d assertion failures",
             value_errors, timeouts, assert_fails);
    if (value_errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : cdc_fifo_tb

`default_nettype wire

//--- cdc_fifo.f
logic/cdc_fifo_pkg.sv
logic/fifo_ram_if.sv
logic/gray_sync.sv
logic/push_flag_mgr.sv
logic/pop_flag_mgr.sv
logic/fifo_ram.sv
logic/cdc_fifo.sv
tests/cdc_fifo_chk.sv
tests/cdc_fifo_tb.sv
